//--- Bender.yml
package:
  name: axis_iq_power

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/iq_power_pkg.sv
      - hdl/axis_iq_split.sv
      - hdl/axis_x2.sv
      - hdl/axis_iq_sum.sv
      - hdl/axis_iq_power.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/axis_iq_power_tb.sv

//--- flist.f
+incdir+hdl
hdl/iq_power_pkg.sv
hdl/axis_iq_split.sv
hdl/axis_x2.sv
hdl/axis_iq_sum.sv
hdl/axis_iq_power.sv
test/axis_iq_power_tb.sv

//--- hdl/axis_iq_power.sv
/*
 * Streaming I/Q power detector
 * computes I²+Q² per lane for every input beat, three cycles latency
 * without back-pressure
 */

`default_nettype none

`include "iq_power_params.svh"

module axis_iq_power (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire iq_power_pkg::iq_beat_t     in_beat,
  input  wire logic                       in_valid,
  output logic                            in_ready,
  output iq_power_pkg::lane_beat_t        out_beat,
  output logic                            out_valid,
  input  wire logic                       out_ready
);

  import iq_power_pkg::*;

  // splitter to squarers
  lane_beat_t i_beat;
  logic       i_valid;
  logic       i_ready;
  lane_beat_t q_beat;
  logic       q_valid;
  logic       q_ready;

  // squarers to adder
  lane_beat_t i2_beat;
  logic       i2_valid;
  logic       i2_ready;
  lane_beat_t q2_beat;
  logic       q2_valid;
  logic       q2_ready;

  axis_iq_split i_split (
    .clk, .reset,
    .in_beat, .in_valid, .in_ready,
    .i_beat, .i_valid, .i_ready,
    .q_beat, .q_valid, .q_ready
  );

  axis_x2 i_x2 (
    .clk, .reset,
    .data_in(i_beat), .data_in_valid(i_valid), .data_in_ready(i_ready),
    .data_out(i2_beat), .data_out_valid(i2_valid), .data_out_ready(i2_ready)
  );

  axis_x2 q_x2 (
    .clk, .reset,
    .data_in(q_beat), .data_in_valid(q_valid), .data_in_ready(q_ready),
    .data_out(q2_beat), .data_out_valid(q2_valid), .data_out_ready(q2_ready)
  );

  axis_iq_sum i_sum (
    .clk, .reset,
    .i2_beat, .i2_valid, .i2_ready,
    .q2_beat, .q2_valid, .q2_ready,
    .out_beat, .out_valid, .out_ready
  );

endmodule

`default_nettype wire

//--- hdl/axis_iq_split.sv
/*
 * I/Q stream splitter
 * forks one I/Q stream into an I stream and a Q stream, each branch
 * accepting at its own pace
 */

`default_nettype none

`include "iq_power_params.svh"

module axis_iq_split (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire iq_power_pkg::iq_beat_t   in_beat,
  input  wire logic                     in_valid,
  output logic                          in_ready,
  output iq_power_pkg::lane_beat_t      i_beat,
  output logic                          i_valid,
  input  wire logic                     i_ready,
  output iq_power_pkg::lane_beat_t      q_beat,
  output logic                          q_valid,
  input  wire logic                     q_ready
);

  import iq_power_pkg::*;

  // set once a branch has taken the current input beat
  logic i_taken;
  logic q_taken;

  // both branches see the same input beat, no latency
  assign i_beat = lane_beat_t'{data: in_beat.i, last: in_beat.last};
  assign q_beat = lane_beat_t'{data: in_beat.q, last: in_beat.last};

  assign i_valid = in_valid && !i_taken;
  assign q_valid = in_valid && !q_taken;

  // input moves on once every branch has its copy
  assign in_ready = (i_taken || i_ready) && (q_taken || q_ready);

  always_ff @(posedge clk) begin
    if (reset) begin
      i_taken <= 1'b0;
      q_taken <= 1'b0;
    end else if (in_valid && in_ready) begin
      i_taken <= 1'b0;
      q_taken <= 1'b0;
    end else begin
      // remember a branch that went ahead while the other stalls
      if (i_valid && i_ready) begin
        i_taken <= 1'b1;
      end
      if (q_valid && q_ready) begin
        q_taken <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/axis_iq_sum.sv
/*
 * I²+Q² adder
 * joins the squared I and Q streams and adds them lane by lane,
 * saturating at the largest positive sample
 */

`default_nettype none

`include "iq_power_params.svh"

module axis_iq_sum (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire iq_power_pkg::lane_beat_t   i2_beat,
  input  wire logic                       i2_valid,
  output logic                            i2_ready,
  input  wire iq_power_pkg::lane_beat_t   q2_beat,
  input  wire logic                       q2_valid,
  output logic                            q2_ready,
  output iq_power_pkg::lane_beat_t        out_beat,
  output logic                            out_valid,
  input  wire logic                       out_ready
);

  import iq_power_pkg::*;

  localparam int SAMPLE_MAX = 2 ** (`IQ_SAMPLE_WIDTH - 1) - 1;

  logic   reg_free;
  logic   take;
  lanes_t sum_data;

  // output register can load when empty or being read
  assign reg_free = !out_valid || out_ready;

  // join, both inputs are taken together or not at all
  assign take     = i2_valid && q2_valid && reg_free;
  assign i2_ready = take;
  assign q2_ready = take;

  always_comb begin
    logic signed [`IQ_SAMPLE_WIDTH:0] wide;
    for (int k = 0; k < `IQ_PARALLEL; k++) begin
      // one extra bit so the sum of two 4.0 squares can't wrap
      wide = $signed(i2_beat.data[k]) + $signed(q2_beat.data[k]);
      if (wide > SAMPLE_MAX) begin
        sum_data[k] = sample_t'(SAMPLE_MAX);
      end else begin
        sum_data[k] = wide[`IQ_SAMPLE_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (reg_free) begin
      out_valid <= i2_valid && q2_valid;
    end
  end

  // both streams carry the same last, take it from I²
  always_ff @(posedge clk) begin
    if (take) begin
      out_beat.data <= sum_data;
      out_beat.last <= i2_beat.last;
    end
  end

endmodule

`default_nettype wire

//--- hdl/axis_x2.sv
/*
 * Streaming squarer
 * squares every lane in a two-stage pipeline and rounds the product
 * to the output format, carrying last alongside the data
 */

`default_nettype none

`include "iq_power_params.svh"

module axis_x2 (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire iq_power_pkg::lane_beat_t   data_in,
  input  wire logic                       data_in_valid,
  output logic                            data_in_ready,
  output iq_power_pkg::lane_beat_t        data_out,
  output logic                            data_out_valid,
  input  wire logic                       data_out_ready
);

  import iq_power_pkg::*;

  // low product bits dropped by the rounding
  localparam int DROP_BITS = 2 * `IQ_FRAC_BITS - `IQ_OUT_FRAC_BITS;
  localparam int PROD_WIDTH = 2 * `IQ_SAMPLE_WIDTH;

  // stage 1, full precision products
  logic                          s1_valid;
  logic                          s1_last;
  logic signed [PROD_WIDTH-1:0]  s1_prod [`IQ_PARALLEL];

  // stage 2, rounded squares
  logic   s2_valid;
  logic   s2_last;
  lanes_t s2_data;

  logic   s1_load;
  logic   s2_load;
  lanes_t rounded;

  // a stage loads when empty or when its content moves on this cycle
  assign s2_load = !s2_valid || data_out_ready;
  assign s1_load = !s1_valid || s2_load;

  assign data_in_ready = s1_load;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (s1_load) begin
      s1_valid <= data_in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_load && data_in_valid) begin
      for (int k = 0; k < `IQ_PARALLEL; k++) begin
        s1_prod[k] <= $signed(data_in.data[k]) * $signed(data_in.data[k]);
      end
      s1_last <= data_in.last;
    end
  end

  // round half up: keep the upper bits, add the highest dropped bit
  always_comb begin
    for (int k = 0; k < `IQ_PARALLEL; k++) begin
      rounded[k] = s1_prod[k][DROP_BITS +: `IQ_SAMPLE_WIDTH]
                   + {{(`IQ_SAMPLE_WIDTH-1){1'b0}}, s1_prod[k][DROP_BITS-1]};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s2_valid <= 1'b0;
    end else if (s2_load) begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_load && s1_valid) begin
      s2_data <= rounded;
      s2_last <= s1_last;
    end
  end

  assign data_out_valid = s2_valid;
  assign data_out.data  = s2_data;
  assign data_out.last  = s2_last;

endmodule

`default_nettype wire

//--- hdl/iq_power_params.svh
/*
 * I/Q power detector widths
 * sample format, fraction bits and lane count shared by every block
 */

`ifndef IQ_POWER_PARAMS_SVH
`define IQ_POWER_PARAMS_SVH

// signed fixed point samples, Q2.14
`define IQ_SAMPLE_WIDTH 16
`define IQ_FRAC_BITS 14

// lanes carried per beat
`define IQ_PARALLEL 2

// squares and power keep twice the integer bits, Q4.12
`define IQ_OUT_FRAC_BITS (`IQ_SAMPLE_WIDTH - 2 * (`IQ_SAMPLE_WIDTH - `IQ_FRAC_BITS))

`endif

//--- hdl/iq_power_pkg.sv
/*
 * I/Q power detector types
 * samples, lane vectors and the stream beats used between blocks
 */

`default_nettype none

`include "iq_power_params.svh"

package iq_power_pkg;

  // one signed fixed point sample
  typedef logic signed [`IQ_SAMPLE_WIDTH-1:0] sample_t;

  // all lanes of one beat, lane 0 in the low bits
  typedef sample_t [`IQ_PARALLEL-1:0] lanes_t;

  // input beat, in-phase and quadrature lanes side by side
  typedef struct packed {
    lanes_t i;
    lanes_t q;
    logic   last;
  } iq_beat_t;

  // single stream beat for the I, Q, squared and power streams
  typedef struct packed {
    lanes_t data;
    logic   last;
  } lane_beat_t;

endpackage

`default_nettype wire

//--- test/axis_iq_power_tb.sv
/*
 * Testbench for the streaming I/Q power detector
 * directed tests against a reference model with a scoreboard queue
 */

`default_nettype none

`include "iq_power_params.svh"

module axis_iq_power_tb;

  import iq_power_pkg::*;

  localparam int N_KNOWN = 4;
  localparam int N_ROUND = 3;
  localparam int N_STREAM = 200;
  localparam int N_BP = 300;
  localparam int TOTAL_BEATS = N_KNOWN + N_ROUND + N_STREAM + N_BP;
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20;
  localparam int DRAIN_CYCLES = 100;

  localparam sample_t S_ZERO = sample_t'(0);
  localparam sample_t S_ONE = sample_t'(1 << `IQ_FRAC_BITS);
  localparam sample_t S_NEG_ONE = sample_t'(-(1 << `IQ_FRAC_BITS));
  localparam sample_t S_HALF = sample_t'(1 << (`IQ_FRAC_BITS - 1));
  localparam sample_t S_NEG_HALF = sample_t'(-(1 << (`IQ_FRAC_BITS - 1)));
  localparam sample_t S_NEG_TWO = sample_t'(-(2 << `IQ_FRAC_BITS));

  logic       clk;
  logic       reset;
  iq_beat_t   in_beat;
  logic       in_valid;
  logic       in_ready;
  lane_beat_t out_beat;
  logic       out_valid;
  logic       out_ready;

  lane_beat_t exp_q[$];
  lane_beat_t mon_exp;
  logic [31:0] lcg_state;
  logic [31:0] ready_state;
  logic        random_ready;
  logic        random_now;
  int err_count;
  int pass_count;
  int fail_count;
  int in_lasts;
  int out_lasts;

  axis_iq_power i_axis_iq_power (
    .clk, .reset,
    .in_beat, .in_valid, .in_ready,
    .out_beat, .out_valid, .out_ready
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_step(lcg_state);
    return lcg_state;
  endfunction

  // square rounded to the nearest output step with ties upward
  function automatic longint square_rounded(sample_t s);
    longint p;
    longint step;
    step = longint'(1) << (2 * `IQ_FRAC_BITS - `IQ_OUT_FRAC_BITS);
    p = longint'(s) * longint'(s);
    return p / step + (((p % step) >= step / 2) ? 1 : 0);
  endfunction

  function automatic lane_beat_t expected_beat(iq_beat_t b);
    lane_beat_t r;
    longint sum;
    longint max_pos;
    max_pos = (longint'(1) << (`IQ_SAMPLE_WIDTH - 1)) - 1;
    for (int k = 0; k < `IQ_PARALLEL; k++) begin
      sum = square_rounded(b.i[k]) + square_rounded(b.q[k]);
      r.data[k] = (sum > max_pos) ? sample_t'(max_pos) : sample_t'(sum);
    end
    r.last = b.last;
    return r;
  endfunction

  function automatic iq_beat_t make_iq(sample_t i0, sample_t q0, sample_t i1, sample_t q1,
                                       logic last);
    iq_beat_t b;
    b.i[0] = i0;
    b.q[0] = q0;
    b.i[1] = i1;
    b.q[1] = q1;
    b.last = last;
    return b;
  endfunction

  function automatic iq_beat_t random_beat(logic last);
    iq_beat_t b;
    logic [31:0] r;
    for (int k = 0; k < `IQ_PARALLEL; k++) begin
      r = next_rand();
      b.i[k] = r[31:16];
      r = next_rand();
      b.q[k] = r[31:16];
    end
    b.last = last;
    return b;
  endfunction

  task automatic compare_lanes(string name, lanes_t got, lanes_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic compare_last(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic compare_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  // input transfers push expected beats and output transfers pop them
  always @(posedge clk) begin
    if (!reset) begin
      if (in_valid && in_ready) begin
        exp_q.push_back(expected_beat(in_beat));
        if (in_beat.last) in_lasts++;
      end
      if (out_valid && out_ready) begin
        if (out_beat.last) out_lasts++;
        if (exp_q.size() == 0) begin
          $display("output beat at %0t arrived with nothing expected", $time);
          err_count++;
        end else begin
          mon_exp = exp_q.pop_front();
          compare_lanes("out_beat.data", out_beat.data, mon_exp.data);
          compare_last("out_beat.last", out_beat.last, mon_exp.last);
        end
      end
    end
  end

  // random output back-pressure while enabled
  always @(posedge clk) begin
    random_now = random_ready;
    #1;
    ready_state = lcg_step(ready_state);
    if (random_now) begin
      out_ready = ready_state[19];
    end else begin
      out_ready = 1'b1;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the DUT stopped moving", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  // starts and ends one time unit after a rising edge
  task automatic send_beat(iq_beat_t b, int gaps);
    in_valid = 1'b0;
    repeat (gaps) begin
      @(posedge clk);
      #1;
    end
    in_beat = b;
    in_valid = 1'b1;
    do begin
      @(posedge clk);
    end while (!in_ready);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain(string name);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_CYCLES) begin
      @(posedge clk);
      n++;
    end
    #1;
    if (exp_q.size() != 0) begin
      $display("%s: %0d expected beats never came out", name, exp_q.size());
      err_count++;
      exp_q.delete();
    end
  endtask

  task automatic finish_test(string name, int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("%s: done, ok", name);
    end else begin
      fail_count++;
      $display("%s: done with %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic test_reset();
    int errs;
    int n;
    errs = err_count;
    reset = 1'b1;
    repeat (10) begin
      @(posedge clk);
      #1;
      compare_flag("out_valid", out_valid, 1'b0);
    end
    reset = 1'b0;
    n = 0;
    while (!in_ready && n < 4) begin
      @(posedge clk);
      #1;
      n++;
    end
    compare_flag("in_ready", in_ready, 1'b1);
    repeat (2) begin
      @(posedge clk);
      #1;
      compare_flag("out_valid", out_valid, 1'b0);
    end
    finish_test("reset", errs);
  endtask

  task automatic test_known_values();
    int errs;
    errs = err_count;
    send_beat(make_iq(S_ZERO, S_ZERO, S_ONE, S_ZERO, 1'b0), 0);
    send_beat(make_iq(S_ONE, S_HALF, S_NEG_ONE, S_ONE, 1'b1), 0);
    send_beat(make_iq(S_NEG_ONE, S_NEG_ONE, S_HALF, S_HALF, 1'b0), 2);
    send_beat(make_iq(S_HALF, S_NEG_HALF, S_ZERO, S_NEG_ONE, 1'b1), 1);
    wait_drain("known values");
    finish_test("known values", errs);
  endtask

  task automatic test_round_saturate();
    int errs;
    errs = err_count;
    // no square lands exactly halfway between two output steps
    // 182 squared sits just above the midpoint and 181 squared just below
    send_beat(make_iq(sample_t'(182), S_ZERO, sample_t'(181), S_ZERO, 1'b0), 0);
    send_beat(make_iq(S_NEG_TWO, S_ZERO, S_ZERO, S_NEG_TWO, 1'b0), 0);
    send_beat(make_iq(S_NEG_TWO, S_NEG_TWO, S_NEG_TWO, S_NEG_TWO, 1'b1), 0);
    wait_drain("rounding and saturation");
    finish_test("rounding and saturation", errs);
  endtask

  task automatic test_stream();
    int errs;
    errs = err_count;
    for (int n = 0; n < N_STREAM; n++) begin
      send_beat(random_beat(n == N_STREAM - 1), 0);
    end
    wait_drain("stream integrity");
    finish_test("stream integrity", errs);
  endtask

  task automatic test_back_pressure();
    int errs;
    logic [31:0] r;
    errs = err_count;
    in_lasts = 0;
    out_lasts = 0;
    random_ready = 1'b1;
    for (int n = 0; n < N_BP; n++) begin
      r = next_rand();
      send_beat(random_beat(r[10:8] == 3'd0 || n == N_BP - 1), int'(r[17:16]));
    end
    wait_drain("back-pressure");
    random_ready = 1'b0;
    if (in_lasts != out_lasts) begin
      $display("back-pressure: %0d last markers sent but %0d received", in_lasts, out_lasts);
      err_count++;
    end
    finish_test("back-pressure", errs);
  endtask

  initial begin
    lcg_state = 32'd33;
    ready_state = 32'd33;
    reset = 1'b1;
    in_beat = '0;
    in_valid = 1'b0;
    out_ready = 1'b1;
    random_ready = 1'b0;
    err_count = 0;
    pass_count = 0;
    fail_count = 0;
    in_lasts = 0;
    out_lasts = 0;
    test_reset();
    test_known_values();
    test_round_saturate();
    test_stream();
    test_back_pressure();
    $display("summary: %0d tests ok, %0d tests with errors", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
